// ==== Makefile ====
TOP := tb_expr

.PHONY: all build lint clean

all: build
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@grep -q "PASS: all tests" sim.log

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir sim.log

// ==== calc_pkg.sv ====
`include "calc_settings.svh"

package calc_pkg;

	// one token as it arrives
	// code is an operand 0..7 or an operator code
	typedef struct packed {
		logic                is_op;
		logic [`TOKEN_W-1:0] code;
	} token_t;

	// slot contents and final result
	typedef logic signed [`VALUE_W-1:0] value_t;

	// codes 5..7 are undefined and evaluate to zero
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_MUL = 3'd2,
		OP_ABS = 3'd3,
		OP_AT  = 3'd4
	} op_e;

	typedef enum logic {
		MODE_PREFIX  = 1'b0,
		MODE_POSTFIX = 1'b1
	} mode_e;

	// per-slot action for one reduction cycle
	typedef enum logic [1:0] {
		PLAN_HOLD  = 2'd0,
		PLAN_CALC  = 2'd1,
		PLAN_SHIFT = 2'd2
	} plan_e;

	// one accepted input beat, mode only matters on the first one
	typedef struct packed {
		token_t tok;
		logic   last;
		mode_e  mode;
	} in_beat_t;

endpackage

// ==== calc_settings.svh ====
`ifndef CALC_SETTINGS_SVH
`define CALC_SETTINGS_SVH

// ------------------------------
// evaluator sizing
// ------------------------------

// depth of the token window
`define TOKEN_SLOTS 20

// operand value or operator code
`define TOKEN_W 3

// arithmetic word, wraps on overflow
`define VALUE_W 32

`endif

// ==== expr_chk.sv ====
`timescale 1ns/1ns

module expr_chk (
	input logic             clk_2,
	input logic             rst_n,
	input logic             in_req,
	input logic             in_ack,
	input logic             out_req,
	input logic             out_ack,
	input calc_pkg::value_t out_value
);
	import calc_pkg::*;

	int assert_fails = 0;

	// value held until the consumer takes it
	a_value_stable: assert property (@(posedge clk_2) disable iff (!rst_n)
		out_req && !out_ack |=> $stable(out_value))
		else begin
			assert_fails++;
			$error("out_value changed while out_req waited for out_ack");
		end

	a_ack_rise: assert property (@(posedge clk_2) disable iff (!rst_n)
		$rose(in_ack) |-> $past(in_req))
		else begin
			assert_fails++;
			$error("in_ack rose without in_req");
		end

	// return to zero only after the source lets go
	a_ack_fall: assert property (@(posedge clk_2) disable iff (!rst_n)
		$fell(in_ack) |-> !$past(in_req))
		else begin
			assert_fails++;
			$error("in_ack fell while in_req was still high");
		end

	a_req_fall: assert property (@(posedge clk_2) disable iff (!rst_n)
		$fell(out_req) |-> $past(out_ack))
		else begin
			assert_fails++;
			$error("out_req fell before out_ack was seen");
		end

endmodule

bind expr_top expr_chk expr_chk_inst (
	.clk_2     (clk_2),
	.rst_n     (rst_n),
	.in_req    (in_req),
	.in_ack    (in_ack),
	.out_req   (out_req),
	.out_ack   (out_ack),
	.out_value (out_value)
);

// ==== expr_evaluator.sv ====
`timescale 1ns/1ns
`include "calc_settings.svh"

module expr_evaluator (
	input  logic               clk_2,
	input  logic               rst_n,
	input  logic               beat_stb,
	input  calc_pkg::in_beat_t beat,
	output logic               ready,
	input  logic               busy,
	output logic               done_stb,
	output calc_pkg::value_t   result
);
	import calc_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_INPUT,
		ST_REDUCE,
		ST_OUTPUT
	} state_e;

	state_e state;
	state_e state_nxt;

	// window, oldest token lowest, newest token enters at the top
	value_t                  slot_val [`TOKEN_SLOTS-1:0];
	logic [`TOKEN_SLOTS-1:0] op_flags;
	mode_e                   mode_q;

	plan_e  plan [`TOKEN_SLOTS-1:0];
	logic   any_calc;
	value_t calc_val [`TOKEN_SLOTS-1:2];
	value_t tok_val;

	assign tok_val = value_t'(beat.tok.code);

	reduce_planner reduce_planner_inst (
		.mode     (mode_q),
		.op_flags (op_flags),
		.plan     (plan),
		.any_calc (any_calc)
	);

	// ------------------------------
	// one alu per triple top
	// ------------------------------
	for (genvar g = 2; g < `TOKEN_SLOTS; g++) begin : g_alu
		op_e    alu_op;
		value_t alu_a;
		value_t alu_b;

		always_comb begin
			if (mode_q == MODE_PREFIX) begin
				alu_op = op_e'(slot_val[g-2][`TOKEN_W-1:0]);
				alu_a  = slot_val[g-1];
				alu_b  = slot_val[g];
			end else begin
				alu_op = op_e'(slot_val[g][`TOKEN_W-1:0]);
				alu_a  = slot_val[g-2];
				alu_b  = slot_val[g-1];
			end
		end

		slot_alu slot_alu_inst (
			.op (alu_op),
			.a  (alu_a),
			.b  (alu_b),
			.y  (calc_val[g])
		);
	end

	// slot values and operator codes
	always_ff @(posedge clk_2) begin
		if (beat_stb) begin
			// first beat of an expression starts from an empty window
			for (int i = 0; i < `TOKEN_SLOTS - 1; i++) begin
				slot_val[i] <= (state == ST_IDLE) ? '0 : slot_val[i+1];
			end
			slot_val[`TOKEN_SLOTS-1] <= tok_val;
		end else if (state == ST_REDUCE) begin
			for (int i = 2; i < `TOKEN_SLOTS; i++) begin
				case (plan[i])
					PLAN_CALC:  slot_val[i] <= calc_val[i];
					PLAN_SHIFT: slot_val[i] <= slot_val[i-2];
					default:    slot_val[i] <= slot_val[i];
				endcase
			end
			// nothing below the bottom two, fill with an empty operand
			for (int i = 0; i < 2; i++) begin
				if (plan[i] == PLAN_SHIFT) begin
					slot_val[i] <= '0;
				end
			end
		end
	end

	always_ff @(posedge clk_2 or negedge rst_n) begin
		if (!rst_n) begin
			op_flags <= '0;
		end else if (beat_stb) begin
			if (state == ST_IDLE) begin
				op_flags <= {beat.tok.is_op, {(`TOKEN_SLOTS-1){1'b0}}};
			end else begin
				op_flags <= {beat.tok.is_op, op_flags[`TOKEN_SLOTS-1:1]};
			end
		end else if (state == ST_REDUCE) begin
			for (int i = 2; i < `TOKEN_SLOTS; i++) begin
				case (plan[i])
					PLAN_CALC:  op_flags[i] <= 1'b0;
					PLAN_SHIFT: op_flags[i] <= op_flags[i-2];
					default:    op_flags[i] <= op_flags[i];
				endcase
			end
			for (int i = 0; i < 2; i++) begin
				if (plan[i] == PLAN_SHIFT) begin
					op_flags[i] <= 1'b0;
				end
			end
		end
	end

	// ------------------------------
	// control
	// ------------------------------
	always_ff @(posedge clk_2 or negedge rst_n) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			mode_q   <= MODE_PREFIX;
			done_stb <= 1'b0;
		end else begin
			state    <= state_nxt;
			done_stb <= (state == ST_REDUCE) && !any_calc;
			if (beat_stb && state == ST_IDLE) begin
				mode_q <= beat.mode;
			end
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (beat_stb) begin
					state_nxt = beat.last ? ST_REDUCE : ST_INPUT;
				end
			end
			ST_INPUT: begin
				if (beat_stb && beat.last) begin
					state_nxt = ST_REDUCE;
				end
			end
			ST_REDUCE: begin
				if (!any_calc) begin
					state_nxt = ST_OUTPUT;
				end
			end
			ST_OUTPUT: begin
				// busy only rises the cycle after done_stb
				if (!done_stb && !busy) begin
					state_nxt = ST_IDLE;
				end
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	assign ready  = (state == ST_IDLE) || (state == ST_INPUT);
	assign result = slot_val[`TOKEN_SLOTS-1];

endmodule

// ==== expr_top.sv ====
`timescale 1ns/1ns
`include "calc_settings.svh"

module expr_top (
	input  logic                      clk_2,
	input  logic                      rst_n,
	input  logic                      in_req,
	// {is_op, code, last, mode}
	input  logic [`TOKEN_W+2:0]       in_beat,
	output logic                      in_ack,
	output logic                      out_req,
	output logic signed [`VALUE_W-1:0] out_value,
	input  logic                      out_ack
);
	import calc_pkg::*;

	in_beat_t beat;
	logic     beat_stb;
	logic     ready;
	logic     busy;
	logic     done_stb;
	value_t   result;

	// token input side
	token_rx token_rx_inst (
		.clk_2    (clk_2),
		.rst_n    (rst_n),
		.in_req   (in_req),
		.in_beat  (in_beat),
		.in_ack   (in_ack),
		.ready    (ready),
		.beat_stb (beat_stb),
		.beat     (beat)
	);

	expr_evaluator expr_evaluator_inst (
		.clk_2    (clk_2),
		.rst_n    (rst_n),
		.beat_stb (beat_stb),
		.beat     (beat),
		.ready    (ready),
		.busy     (busy),
		.done_stb (done_stb),
		.result   (result)
	);

	// result output side
	result_tx result_tx_inst (
		.clk_2     (clk_2),
		.rst_n     (rst_n),
		.done_stb  (done_stb),
		.result    (result),
		.busy      (busy),
		.out_req   (out_req),
		.out_value (out_value),
		.out_ack   (out_ack)
	);

endmodule

// ==== reduce_planner.sv ====
`timescale 1ns/1ns
`include "calc_settings.svh"

module reduce_planner (
	input  calc_pkg::mode_e         mode,
	input  logic [`TOKEN_SLOTS-1:0] op_flags,
	output calc_pkg::plan_e         plan [`TOKEN_SLOTS-1:0],
	output logic                    any_calc
);
	import calc_pkg::*;

	// slot i is the top of a reducible triple i-2, i-1, i
	logic [`TOKEN_SLOTS-1:0] match;

	always_comb begin
		match = '0;
		for (int i = 2; i < `TOKEN_SLOTS; i++) begin
			if (mode == MODE_PREFIX) begin
				// operator, value, value
				match[i] = op_flags[i-2] & ~op_flags[i-1] & ~op_flags[i];
			end else begin
				// value, value, operator
				match[i] = ~op_flags[i-2] & ~op_flags[i-1] & op_flags[i];
			end
		end
	end

	// ------------------------------
	// top-down claim chain
	// ------------------------------
	// the topmost match collapses, everything under it moves up by two
	// and a later match below simply waits for a following cycle
	always_comb begin
		any_calc = 1'b0;
		for (int i = `TOKEN_SLOTS - 1; i >= 0; i--) begin
			if (any_calc) begin
				plan[i] = PLAN_SHIFT;
			end else if (match[i]) begin
				plan[i]  = PLAN_CALC;
				any_calc = 1'b1;
			end else begin
				plan[i] = PLAN_HOLD;
			end
		end
	end

endmodule

// ==== result_tx.sv ====
`timescale 1ns/1ns

module result_tx (
	input  logic             clk_2,
	input  logic             rst_n,
	input  logic             done_stb,
	input  calc_pkg::value_t result,
	output logic             busy,
	output logic             out_req,
	output calc_pkg::value_t out_value,
	input  logic             out_ack
);

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_REQ,
		TX_RELEASE
	} tx_state_e;

	tx_state_e state;

	// ------------------------------
	// four-phase request
	// ------------------------------
	always_ff @(posedge clk_2 or negedge rst_n) begin
		if (!rst_n) begin
			state <= TX_IDLE;
		end else begin
			case (state)
				TX_IDLE: begin
					if (done_stb) begin
						state <= TX_REQ;
					end
				end
				TX_REQ: begin
					// consumer has taken the value
					if (out_ack) begin
						state <= TX_RELEASE;
					end
				end
				TX_RELEASE: begin
					if (!out_ack) begin
						state <= TX_IDLE;
					end
				end
				default: begin
					state <= TX_IDLE;
				end
			endcase
		end
	end

	// held until the next expression completes
	always_ff @(posedge clk_2) begin
		if (done_stb) begin
			out_value <= result;
		end
	end

	assign out_req = (state == TX_REQ);
	assign busy    = (state != TX_IDLE);

endmodule

// ==== slot_alu.sv ====
`timescale 1ns/1ns

module slot_alu (
	input  calc_pkg::op_e    op,
	input  calc_pkg::value_t a,
	input  calc_pkg::value_t b,
	output calc_pkg::value_t y
);
	import calc_pkg::*;

	value_t sum;
	value_t diff;

	// a is the earlier operand in token order
	assign sum  = a + b;
	assign diff = a - b;

	always_comb begin
		case (op)
			OP_ADD: begin
				y = sum;
			end
			OP_SUB: begin
				y = diff;
			end
			OP_MUL: begin
				// low word of the product
				y = a * b;
			end
			OP_ABS: begin
				y = (sum < 0) ? -sum : sum;
			end
			OP_AT: begin
				y = diff << 1;
			end
			default: begin
				y = '0;
			end
		endcase
	end

endmodule

// ==== tb.f ====
+incdir+.
calc_pkg.sv
token_rx.sv
reduce_planner.sv
slot_alu.sv
expr_evaluator.sv
result_tx.sv
expr_top.sv
expr_chk.sv
tb_expr.sv

// ==== tb_expr.sv ====
`timescale 1ns/1ns
`include "calc_settings.svh"

module tb_expr;
	import calc_pkg::*;

	typedef logic signed [`VALUE_W-1:0] word_t;

	localparam int NUM_DIRECTED = 5;
	localparam int NUM_RANDOM   = 200;
	localparam int NUM_EXPR     = NUM_DIRECTED + NUM_RANDOM;
	// generous per-expression budget, longest case needs well under it
	localparam int CYCLE_LIMIT  = NUM_EXPR * 200;

	logic                clk_2;
	logic                rst_n;
	logic                in_req;
	logic [`TOKEN_W+2:0] in_beat;
	logic                in_ack;
	logic                out_req;
	word_t               out_value;
	logic                out_ack;

	logic [31:0] lfsr;
	token_t      tok_q [$];
	word_t       expect_q [$];
	int          op_seen [5];
	int          abs_neg_seen;
	int          at_neg_seen;
	int          single_seen;
	int          cycle_cnt;

	expr_top expr_top_inst (
		.clk_2     (clk_2),
		.rst_n     (rst_n),
		.in_req    (in_req),
		.in_beat   (in_beat),
		.in_ack    (in_ack),
		.out_req   (out_req),
		.out_value (out_value),
		.out_ack   (out_ack)
	);

	initial begin
		clk_2 = 1'b0;
		forever begin
			#4 clk_2 = ~clk_2;
		end
	end

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	always @(posedge clk_2) begin
		cycle_cnt <= cycle_cnt + 1;
		assert (cycle_cnt < CYCLE_LIMIT) else begin
			report_error($sformatf("timeout, run not finished after %0d cycles", cycle_cnt));
		end
	end

	// galois lfsr, one step per bit
	function automatic int rand_bits(int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			r = (r << 1) | int'(lfsr[0]);
		end
		return r;
	endfunction

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic word_t apply_op(logic [2:0] code, word_t a, word_t b);
		word_t s;
		word_t d;
		word_t y;
		s = a + b;
		d = a - b;
		op_seen[int'(code)]++;
		case (op_e'(code))
			OP_ADD: y = s;
			OP_SUB: y = d;
			OP_MUL: y = a * b;
			OP_ABS: begin
				if (s < 0) begin
					abs_neg_seen++;
				end
				y = (s < 0) ? -s : s;
			end
			OP_AT: begin
				if (d < 0) begin
					at_neg_seen++;
				end
				y = d <<< 1;
			end
			default: y = '0;
		endcase
		return y;
	endfunction

	// stack machine, prefix read back to front
	function automatic word_t model_eval(mode_e mode);
		word_t  stack [$];
		word_t  a;
		word_t  b;
		token_t t;
		int     n;
		n = tok_q.size();
		for (int k = 0; k < n; k++) begin
			t = (mode == MODE_PREFIX) ? tok_q[n-1-k] : tok_q[k];
			if (!t.is_op) begin
				stack.push_back(word_t'(t.code));
			end else if (mode == MODE_PREFIX) begin
				a = stack.pop_back();
				b = stack.pop_back();
				stack.push_back(apply_op(t.code, a, b));
			end else begin
				b = stack.pop_back();
				a = stack.pop_back();
				stack.push_back(apply_op(t.code, a, b));
			end
		end
		if (n == 1) begin
			single_seen++;
		end
		return stack.pop_back();
	endfunction

	// ------------------------------
	// expression generation
	// ------------------------------
	function automatic void add_val(int v);
		token_t t;
		t.is_op = 1'b0;
		t.code  = 3'(v);
		tok_q.push_back(t);
	endfunction

	function automatic void add_op(op_e op);
		token_t t;
		t.is_op = 1'b1;
		t.code  = op;
		tok_q.push_back(t);
	endfunction

	task automatic load_directed(input int idx, output mode_e mode);
		tok_q.delete();
		mode = MODE_PREFIX;
		case (idx)
			0: begin
				add_val(5);
			end
			1: begin
				mode = MODE_POSTFIX;
				add_val(7);
			end
			2: begin
				// |(1 - 7) + 2|
				add_op(OP_ABS);
				add_op(OP_SUB);
				add_val(1);
				add_val(7);
				add_val(2);
			end
			3: begin
				// (2 - 5) shifted, negative
				mode = MODE_POSTFIX;
				add_val(2);
				add_val(5);
				add_op(OP_AT);
			end
			default: begin
				add_op(OP_MUL);
				add_op(OP_ADD);
				add_val(3);
				add_val(4);
				add_op(OP_AT);
				add_val(1);
				add_val(6);
			end
		endcase
	endtask

	task automatic make_random_expr(output mode_e mode);
		int     ops_left;
		int     vals_left;
		int     depth;
		token_t t;
		mode      = rand_bits(1) ? MODE_POSTFIX : MODE_PREFIX;
		ops_left  = rand_bits(4) % 10;
		vals_left = ops_left + 1;
		depth     = 0;
		tok_q.delete();
		while (ops_left + vals_left > 0) begin
			if (vals_left > 0 && (depth < 2 || ops_left == 0 || rand_bits(1) == 1)) begin
				t.is_op = 1'b0;
				t.code  = 3'(rand_bits(3));
				vals_left--;
				depth++;
			end else begin
				t.is_op = 1'b1;
				t.code  = 3'(rand_bits(3) % 5);
				ops_left--;
				depth--;
			end
			// built as postfix, reversed it is the prefix of the mirrored tree
			if (mode == MODE_POSTFIX) begin
				tok_q.push_back(t);
			end else begin
				tok_q.push_front(t);
			end
		end
	endtask

	// ------------------------------
	// handshakes
	// ------------------------------
	task automatic send_beat(input token_t tok, input logic last, input mode_e mode);
		repeat (rand_bits(2)) @(negedge clk_2);
		in_beat = {tok, last, mode};
		in_req  = 1'b1;
		@(negedge clk_2);
		while (!in_ack) begin
			@(negedge clk_2);
		end
		in_req = 1'b0;
		@(negedge clk_2);
		while (in_ack) begin
			@(negedge clk_2);
		end
	endtask

	task automatic send_expression(input mode_e mode);
		int n;
		n = tok_q.size();
		expect_q.push_back(model_eval(mode));
		for (int k = 0; k < n; k++) begin
			send_beat(tok_q[k], k == n - 1, mode);
		end
	endtask

	task automatic drive_tokens();
		mode_e mode;
		for (int e = 0; e < NUM_DIRECTED; e++) begin
			load_directed(e, mode);
			send_expression(mode);
		end
		// coverage counts only the random expressions
		abs_neg_seen = 0;
		at_neg_seen  = 0;
		single_seen  = 0;
		foreach (op_seen[i]) begin
			op_seen[i] = 0;
		end
		for (int e = 0; e < NUM_RANDOM; e++) begin
			make_random_expr(mode);
			send_expression(mode);
		end
	endtask

	task automatic check_result(input word_t exp_val);
		assert (out_value === exp_val) else begin
			report_error($sformatf("FAIL out_value: got 0x%h, expected 0x%h",
				out_value, exp_val));
		end
		assert (!in_ack) else begin
			report_error("a new token was acknowledged while a result was still pending");
		end
	endtask

	task automatic take_result(input int idx);
		word_t exp_val;
		int    gap;
		while (!out_req) begin
			@(negedge clk_2);
		end
		assert (expect_q.size() > 0) else begin
			report_error("a result was offered with no expression outstanding");
		end
		exp_val = expect_q.pop_front();
		check_result(exp_val);
		// directed cases hold off out_ack long enough to stall the next tokens
		gap = (idx < NUM_DIRECTED) ? 12 : rand_bits(4);
		for (int c = 0; c < gap; c++) begin
			@(negedge clk_2);
			assert (out_req) else begin
				report_error("out_req dropped before out_ack was raised");
			end
			check_result(exp_val);
		end
		out_ack = 1'b1;
		@(negedge clk_2);
		while (out_req) begin
			@(negedge clk_2);
		end
		out_ack = 1'b0;
	endtask

	task automatic collect_results();
		for (int e = 0; e < NUM_EXPR; e++) begin
			take_result(e);
		end
	endtask

	task automatic check_coverage();
		for (int i = 0; i < 5; i++) begin
			assert (op_seen[i] > 0) else begin
				report_error($sformatf("operator code %0d never occurred", i));
			end
		end
		assert (abs_neg_seen > 0) else begin
			report_error("abs never saw a negative sum");
		end
		assert (at_neg_seen > 0) else begin
			report_error("at never saw a negative difference");
		end
		assert (single_seen > 0) else begin
			report_error("no single operand expression was sent");
		end
	endtask

	initial begin
		rst_n        = 1'b0;
		in_req       = 1'b0;
		in_beat      = '0;
		out_ack      = 1'b0;
		lfsr         = 32'd52;
		cycle_cnt    = 0;
		abs_neg_seen = 0;
		at_neg_seen  = 0;
		single_seen  = 0;
		foreach (op_seen[i]) begin
			op_seen[i] = 0;
		end
		repeat (10) @(posedge clk_2);
		@(negedge clk_2);
		rst_n = 1'b1;
		@(negedge clk_2);
		assert (!in_ack && !out_req) else begin
			report_error("in_ack or out_req is high right after reset");
		end
		fork
			drive_tokens();
			collect_results();
		join
		check_coverage();
		if (expr_top_inst.expr_chk_inst.assert_fails == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			report_error("handshake assertions in expr_chk failed");
		end
	end

endmodule

// ==== token_rx.sv ====
`timescale 1ns/1ns

module token_rx (
	input  logic               clk_2,
	input  logic               rst_n,
	input  logic               in_req,
	input  calc_pkg::in_beat_t in_beat,
	output logic               in_ack,
	input  logic               ready,
	output logic               beat_stb,
	output calc_pkg::in_beat_t beat
);

	typedef enum logic {
		RX_IDLE,
		RX_ACK
	} rx_state_e;

	rx_state_e state;
	logic      take;

	// new request while the evaluator can accept a token
	assign take = (state == RX_IDLE) && in_req && ready;

	// ------------------------------
	// four-phase acknowledge
	// ------------------------------
	always_ff @(posedge clk_2 or negedge rst_n) begin
		if (!rst_n) begin
			state    <= RX_IDLE;
			beat_stb <= 1'b0;
		end else begin
			beat_stb <= take;
			if (take) begin
				state <= RX_ACK;
			end else if (state == RX_ACK && !in_req) begin
				// source has released, return to zero
				state <= RX_IDLE;
			end
		end
	end

	// beat is stable while in_req is high
	always_ff @(posedge clk_2) begin
		if (take) begin
			beat <= in_beat;
		end
	end

	assign in_ack = (state == RX_ACK);

endmodule
